// ==== src/cam_rx_pkg.sv ====
package cam_rx_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int LANE_W          = 8;
    localparam int WINDOW_W        = 55;   // A 12-bit group at offset 7 ends on bit 54.
    localparam int PIX_W           = 16;
    localparam int ADDR_W          = 9;
    localparam int CODE_W          = 48;   // Four words of the widest format.
    localparam int MAX_LINE_PIXELS = 510;

    typedef logic [LANE_W-1:0]   lvds_byte_t;
    typedef logic [WINDOW_W-1:0] window_t;
    typedef logic [2:0]          bit_offset_t;
    typedef logic [PIX_W-1:0]    pixel_t;
    typedef logic [ADDR_W-1:0]   line_addr_t;
    typedef logic [CODE_W-1:0]   sync_code_t;

    typedef enum logic [1:0] {
        FMT_NONE,
        FMT_8,
        FMT_10,
        FMT_12
    } pixel_format_e;

    // Lane bytes that carry one group of four pixels.
    localparam int GROUP_BYTES_8  = 4;
    localparam int GROUP_BYTES_10 = 5;
    localparam int GROUP_BYTES_12 = 6;

    // ----------------------------------------------------------------------
    // Sync codes, indexed by pixel_format_e
    // ----------------------------------------------------------------------
    // The FMT_NONE entry is never compared. Narrow codes are zero-extended.
    localparam sync_code_t SAV_VALID [4] = '{
        48'h0,
        {16'h0, 8'hFF, 8'h00, 8'h00, 8'h80},
        {8'h0, 10'h3FF, 10'h000, 10'h000, 10'h200},
        {12'hFFF, 12'h000, 12'h000, 12'h800}
    };

    localparam sync_code_t SAV_INVALID [4] = '{
        48'h0,
        {16'h0, 8'hFF, 8'h00, 8'h00, 8'hAB},
        {8'h0, 10'h3FF, 10'h000, 10'h000, 10'h2AC},
        {12'hFFF, 12'h000, 12'h000, 12'hAB0}
    };

    localparam sync_code_t EAV_VALID [4] = '{
        48'h0,
        {16'h0, 8'hFF, 8'h00, 8'h00, 8'h9D},
        {8'h0, 10'h3FF, 10'h000, 10'h000, 10'h274},
        {12'hFFF, 12'h000, 12'h000, 12'h9D0}
    };

    localparam sync_code_t EAV_INVALID [4] = '{
        48'h0,
        {16'h0, 8'hFF, 8'h00, 8'h00, 8'hB6},
        {8'h0, 10'h3FF, 10'h000, 10'h000, 10'h2D8},
        {12'hFFF, 12'h000, 12'h000, 12'hB60}
    };

endpackage

// ==== src/line_sync_detect.sv ====
`timescale 1ns/100ps

module line_sync_detect (
    input  logic                          camera_clk,
    input  logic                          rst,
    input  logic                          i_xhs,
    input  cam_rx_pkg::lvds_byte_t        i_lvds,
    output cam_rx_pkg::window_t           o_window,
    output logic                          o_hs_rise,
    output logic                          o_hs_fall,
    output logic                          o_sav_hit,
    output cam_rx_pkg::pixel_format_e     o_sav_format,
    output cam_rx_pkg::bit_offset_t       o_sav_offset,
    output logic                          o_code_reject
);
    import cam_rx_pkg::*;

    logic [2:0]  xhs_sr;        // Two sync flops plus the previous value.
    logic [23:0] sav_match;     // Bit (format - 1) * 8 + offset.
    logic [23:0] reject_match;

    always_ff @(posedge camera_clk) begin
        if (rst) begin
            o_window  <= '0;
            xhs_sr    <= '0;
            o_hs_rise <= 1'b0;
            o_hs_fall <= 1'b0;
        end else begin
            // New bytes enter at the bottom, so older bits sit higher.
            o_window  <= {o_window[WINDOW_W-LANE_W-1:0], i_lvds};
            xhs_sr    <= {xhs_sr[1:0], i_xhs};
            o_hs_rise <= (xhs_sr[2:1] == 2'b01);
            o_hs_fall <= (xhs_sr[2:1] == 2'b10);
        end
    end

    // ----------------------------------------------------------------------
    // Code search over every format and bit offset
    // ----------------------------------------------------------------------
    for (genvar f = 1; f <= 3; f++) begin : g_format
        localparam int CW = LANE_W * ((f == 1) ? GROUP_BYTES_8 :
                                      (f == 2) ? GROUP_BYTES_10 : GROUP_BYTES_12);

        for (genvar o = 0; o < 8; o++) begin : g_offset
            logic [CW-1:0] slice;

            assign slice = o_window[o +: CW];
            assign sav_match[(f-1)*8 + o] = (slice == SAV_VALID[f][CW-1:0]);

            // Any other code means the line cannot be trusted.
            assign reject_match[(f-1)*8 + o] = (slice == SAV_INVALID[f][CW-1:0]) ||
                                               (slice == EAV_VALID[f][CW-1:0])   ||
                                               (slice == EAV_INVALID[f][CW-1:0]);
        end
    end

    always_comb begin
        o_sav_format = FMT_NONE;
        o_sav_offset = '0;
        for (int i = 0; i < 24; i++) begin
            if (sav_match[i]) begin
                o_sav_format = pixel_format_e'(i / 8 + 1);
                o_sav_offset = bit_offset_t'(i % 8);
            end
        end
    end

    assign o_sav_hit     = |sav_match;
    assign o_code_reject = |reject_match;

endmodule

// ==== src/pixel_unpack.sv ====
`timescale 1ns/100ps

module pixel_unpack (
    input  logic                          camera_clk,
    input  logic                          rst,
    input  cam_rx_pkg::window_t           i_window,
    input  logic                          i_hs_rise,
    input  logic                          i_hs_fall,
    input  logic                          i_sav_hit,
    input  cam_rx_pkg::pixel_format_e     i_sav_format,
    input  cam_rx_pkg::bit_offset_t       i_sav_offset,
    input  logic                          i_code_reject,
    output logic                          o_pix_strobe,
    output cam_rx_pkg::pixel_t            o_pix_data,
    output logic                          o_line_start,
    output logic                          o_line_end,
    output cam_rx_pkg::pixel_format_e     o_pixel_format
);
    import cam_rx_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_GATHER,
        ST_UNPACK,
        ST_WAIT_HS
    } state_e;

    state_e      state;
    bit_offset_t offset;
    logic [2:0]  group_bytes;
    logic [2:0]  byte_cnt;
    logic [2:0]  pix_left;
    sync_code_t  group;         // Left-aligned, next pixel on top.
    sync_code_t  last_words;    // Last four words, right-aligned.
    sync_code_t  group_now;
    sync_code_t  code_mask;
    pixel_t      pix_word;
    int unsigned word_w;
    logic        capture;
    logic        eav_match;

    always_comb begin
        word_w    = 2 * group_bytes;
        code_mask = {CODE_W{1'b1}} >> (CODE_W - 4 * word_w);
        group_now = sync_code_t'(i_window >> offset) << (CODE_W - 4 * word_w);
        pix_word  = group[CODE_W-1 -: PIX_W] & pixel_t'({PIX_W{1'b1}} << (PIX_W - word_w));
        capture   = (state == ST_GATHER || state == ST_UNPACK) &&
                    (byte_cnt == group_bytes - 3'd1);
        // Only checked right after a word went out.
        eav_match = o_pix_strobe &&
                    ((last_words & code_mask) == EAV_VALID[o_pixel_format]);
    end

    always_ff @(posedge camera_clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            offset         <= '0;
            group_bytes    <= '0;
            byte_cnt       <= '0;
            pix_left       <= '0;
            o_pix_strobe   <= 1'b0;
            o_line_start   <= 1'b0;
            o_line_end     <= 1'b0;
            o_pixel_format <= FMT_NONE;
        end else begin
            o_pix_strobe <= 1'b0;
            o_line_start <= 1'b0;
            o_line_end   <= 1'b0;
            byte_cnt     <= byte_cnt + 3'd1;

            if (state == ST_UNPACK && pix_left != 3'd0 && !eav_match) begin
                o_pix_strobe <= 1'b1;
                pix_left     <= pix_left - 3'd1;
            end
            if (capture) begin
                byte_cnt <= '0;
                pix_left <= 3'd4;
            end

            case (state)
                ST_IDLE: begin
                    if (i_hs_rise) begin
                        state <= ST_SEARCH;
                    end
                end
                ST_SEARCH: begin
                    if (i_code_reject || i_hs_fall) begin
                        state <= ST_IDLE;
                    end else if (i_sav_hit) begin
                        state          <= ST_GATHER;
                        o_line_start   <= 1'b1;
                        o_pixel_format <= i_sav_format;
                        offset         <= i_sav_offset;
                        byte_cnt       <= '0;
                        pix_left       <= '0;
                        case (i_sav_format)
                            FMT_10:  group_bytes <= 3'(GROUP_BYTES_10);
                            FMT_12:  group_bytes <= 3'(GROUP_BYTES_12);
                            default: group_bytes <= 3'(GROUP_BYTES_8);
                        endcase
                    end
                end
                ST_GATHER: begin
                    if (i_hs_fall) begin
                        state <= ST_IDLE;
                    end else if (capture) begin
                        state <= ST_UNPACK;
                    end
                end
                ST_UNPACK: begin
                    if (i_hs_fall) begin
                        state <= ST_IDLE;
                    end else if (eav_match) begin
                        state      <= ST_WAIT_HS;
                        o_line_end <= 1'b1;
                    end
                end
                ST_WAIT_HS: begin
                    if (i_hs_fall) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Group data path.
    always_ff @(posedge camera_clk) begin
        if (state == ST_SEARCH) begin
            last_words <= '0;
        end else if (state == ST_UNPACK && pix_left != 3'd0 && !eav_match) begin
            o_pix_data <= pix_word;
            group      <= group << word_w;
            last_words <= (last_words << word_w) |
                          sync_code_t'(pix_word >> (PIX_W - word_w));
        end
        if (capture) begin
            group <= group_now;
        end
    end

endmodule

// ==== src/line_writer.sv ====
`timescale 1ns/100ps

module line_writer (
    input  logic                      camera_clk,
    input  logic                      rst,
    input  logic                      i_pix_strobe,
    input  cam_rx_pkg::pixel_t        i_pix_data,
    input  logic                      i_line_start,
    input  logic                      i_line_end,
    input  logic                      i_hs_fall,
    output logic                      o_wr_en,
    output cam_rx_pkg::line_addr_t    o_wr_addr,
    output cam_rx_pkg::pixel_t        o_wr_data,
    output logic                      o_wr_bank,
    output cam_rx_pkg::line_addr_t    o_line_length,
    output logic                      o_line_valid
);
    import cam_rx_pkg::*;

    line_addr_t next_addr;
    line_addr_t length;
    logic       overflow;
    logic       done;
    logic       room;

    assign room = (next_addr != line_addr_t'(MAX_LINE_PIXELS));

    always_ff @(posedge camera_clk) begin
        if (rst) begin
            o_wr_en       <= 1'b0;
            o_wr_bank     <= 1'b0;
            o_line_length <= '0;
            o_line_valid  <= 1'b0;
            next_addr     <= '0;
            overflow      <= 1'b0;
            done          <= 1'b0;
        end else begin
            o_wr_en <= 1'b0;
            if (i_line_start) begin
                next_addr <= '0;
                overflow  <= 1'b0;
                done      <= 1'b0;
            end else if (i_pix_strobe) begin
                if (room) begin
                    o_wr_en   <= 1'b1;
                    next_addr <= next_addr + line_addr_t'(1);
                end else begin
                    overflow <= 1'b1;   // The rest of the line is dropped.
                end
            end

            if (i_line_end) begin
                done <= 1'b1;
            end

            // -------------------------------------------------------------
            // Publish at the end of hsync
            // -------------------------------------------------------------
            if (i_hs_fall) begin
                done <= 1'b0;
                if (done && !overflow) begin
                    o_line_length <= length;
                    o_line_valid  <= 1'b1;
                    o_wr_bank     <= ~o_wr_bank;
                end else begin
                    o_line_length <= '0;
                    o_line_valid  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge camera_clk) begin
        if (i_pix_strobe && room) begin
            o_wr_addr <= next_addr;
            o_wr_data <= i_pix_data;
        end
        if (i_line_end) begin
            length <= next_addr - line_addr_t'(4);   // The EAV words are not pixels.
        end
    end

endmodule

// ==== src/line_buffer_ram.sv ====
`timescale 1ns/100ps

module line_buffer_ram (
    input  logic                      camera_clk,
    input  logic                      i_wr_en,
    input  logic                      i_wr_bank,
    input  cam_rx_pkg::line_addr_t    i_wr_addr,
    input  cam_rx_pkg::pixel_t        i_wr_data,
    input  cam_rx_pkg::line_addr_t    i_rd_addr,
    output cam_rx_pkg::pixel_t        o_rd_data
);
    import cam_rx_pkg::*;

    // Bank select is the top address bit.
    pixel_t mem [2**(ADDR_W+1)];

    always_ff @(posedge camera_clk) begin
        if (i_wr_en) begin
            mem[{i_wr_bank, i_wr_addr}] <= i_wr_data;
        end
        o_rd_data <= mem[{~i_wr_bank, i_rd_addr}];   // Reads see the finished line.
    end

endmodule

// ==== src/cam_line_receiver.sv ====
`timescale 1ns/100ps

module cam_line_receiver (
    input  logic                          camera_clk,
    input  logic                          rst,
    input  logic                          i_xhs,
    input  cam_rx_pkg::lvds_byte_t        i_lvds,
    input  cam_rx_pkg::line_addr_t        i_rd_addr,
    output cam_rx_pkg::pixel_t            o_rd_data,
    output cam_rx_pkg::line_addr_t        o_line_length,
    output logic                          o_line_valid,
    output cam_rx_pkg::pixel_format_e     o_pixel_format
);
    import cam_rx_pkg::*;

    window_t       window;
    logic          hs_rise;
    logic          hs_fall;
    logic          sav_hit;
    pixel_format_e sav_format;
    bit_offset_t   sav_offset;
    logic          code_reject;

    logic          pix_strobe;
    pixel_t        pix_data;
    logic          line_start;
    logic          line_end;

    logic          wr_en;
    line_addr_t    wr_addr;
    pixel_t        wr_data;
    logic          wr_bank;

    line_sync_detect line_sync_detect_inst (
        .camera_clk    (camera_clk),
        .rst           (rst),
        .i_xhs         (i_xhs),
        .i_lvds        (i_lvds),
        .o_window      (window),
        .o_hs_rise     (hs_rise),
        .o_hs_fall     (hs_fall),
        .o_sav_hit     (sav_hit),
        .o_sav_format  (sav_format),
        .o_sav_offset  (sav_offset),
        .o_code_reject (code_reject)
    );

    pixel_unpack pixel_unpack_inst (
        .camera_clk     (camera_clk),
        .rst            (rst),
        .i_window       (window),
        .i_hs_rise      (hs_rise),
        .i_hs_fall      (hs_fall),
        .i_sav_hit      (sav_hit),
        .i_sav_format   (sav_format),
        .i_sav_offset   (sav_offset),
        .i_code_reject  (code_reject),
        .o_pix_strobe   (pix_strobe),
        .o_pix_data     (pix_data),
        .o_line_start   (line_start),
        .o_line_end     (line_end),
        .o_pixel_format (o_pixel_format)
    );

    line_writer line_writer_inst (
        .camera_clk    (camera_clk),
        .rst           (rst),
        .i_pix_strobe  (pix_strobe),
        .i_pix_data    (pix_data),
        .i_line_start  (line_start),
        .i_line_end    (line_end),
        .i_hs_fall     (hs_fall),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_wr_bank     (wr_bank),
        .o_line_length (o_line_length),
        .o_line_valid  (o_line_valid)
    );

    line_buffer_ram line_buffer_ram_inst (
        .camera_clk (camera_clk),
        .i_wr_en    (wr_en),
        .i_wr_bank  (wr_bank),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .i_rd_addr  (i_rd_addr),
        .o_rd_data  (o_rd_data)
    );

endmodule

// ==== dv/tb_line_table.svh ====
`ifndef TB_LINE_TABLE_SVH
`define TB_LINE_TABLE_SVH

// Columns are the pixel format, the filler bits before the SAV, the pixel count,
// a valid SAV, hsync falling before the EAV, and the line result expected as valid.
typedef struct packed {
    pixel_format_e fmt;
    logic [2:0]    offset;
    logic [9:0]    pixels;
    logic          sav_ok;
    logic          hs_early;
    logic          exp_valid;
} line_row_t;

localparam int LINE_COUNT = 11;

localparam line_row_t LINE_TABLE [LINE_COUNT] = '{
    '{FMT_8,  3'd0, 10'd32,  1'b1, 1'b0, 1'b1},
    '{FMT_10, 3'd3, 10'd40,  1'b1, 1'b0, 1'b1},
    '{FMT_12, 3'd7, 10'd24,  1'b1, 1'b0, 1'b1},
    '{FMT_8,  3'd5, 10'd48,  1'b1, 1'b1, 1'b0},   // Hsync ends inside the pixels.
    '{FMT_10, 3'd1, 10'd20,  1'b0, 1'b0, 1'b0},   // Invalid SAV.
    '{FMT_12, 3'd2, 10'd20,  1'b1, 1'b0, 1'b1},
    '{FMT_8,  3'd6, 10'd520, 1'b1, 1'b0, 1'b0},   // Overflow.
    '{FMT_10, 3'd6, 10'd13,  1'b1, 1'b0, 1'b1},
    '{FMT_12, 3'd4, 10'd33,  1'b1, 1'b0, 1'b1},
    '{FMT_8,  3'd7, 10'd5,   1'b1, 1'b0, 1'b1},
    '{FMT_8,  3'd1, 10'd506, 1'b1, 1'b0, 1'b1}    // EAV ends on the last free address.
};

`endif

// ==== dv/tb_cam_line_receiver.sv ====
`timescale 1ns/100ps

module tb_cam_line_receiver;
    import cam_rx_pkg::*;

    `include "tb_line_table.svh"

    localparam int IDLE_BYTES    = 8;
    localparam int PAD_BYTES     = 20;
    localparam int SETTLE_CYCLES = 10;

    // Last word of each sync code, top-aligned in a word of any width.
    localparam logic [7:0] TAG_SAV_VALID   = 8'h80;
    localparam logic [7:0] TAG_SAV_INVALID = 8'hAB;
    localparam logic [7:0] TAG_EAV_VALID   = 8'h9D;

    logic          camera_clk = 1'b0;
    logic          rst;
    logic          xhs;
    lvds_byte_t    lvds_data;
    line_addr_t    rd_addr;
    pixel_t        rd_data;
    line_addr_t    line_length;
    logic          line_valid;
    pixel_format_e pixel_format;

    logic [31:0]   rng_state = 32'd82;
    int unsigned   cycle_count = 0;
    int unsigned   cycle_limit;
    int unsigned   error_count = 0;
    bit            stream_bits [$];
    lvds_byte_t    line_bytes [$];
    pixel_t        expected_pixels [$];

    cam_line_receiver cam_line_receiver_inst (
        .camera_clk     (camera_clk),
        .rst            (rst),
        .i_xhs          (xhs),
        .i_lvds         (lvds_data),
        .i_rd_addr      (rd_addr),
        .o_rd_data      (rd_data),
        .o_line_length  (line_length),
        .o_line_valid   (line_valid),
        .o_pixel_format (pixel_format)
    );

    always #10 camera_clk = ~camera_clk;

    always @(posedge camera_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles.", cycle_limit);
            abort_run();
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAIL time=%0t %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pixel_width(input pixel_format_e fmt);
        case (fmt)
            FMT_10:  return 10;
            FMT_12:  return 12;
            default: return 8;
        endcase
    endfunction

    function automatic int unsigned cycle_budget();
        int unsigned total;
        total = 0;
        for (int r = 0; r < LINE_COUNT; r++) begin
            total += 2 * (LINE_TABLE[r].pixels + 40);
        end
        return total;
    endfunction

    task automatic push_word(input logic [15:0] value, input int width);
        for (int i = width - 1; i >= 0; i--) begin
            stream_bits.push_back(value[i]);   // MSB goes first on the lane.
        end
    endtask

    task automatic push_code(input logic [7:0] tag, input int width);
        logic [15:0] ones;
        ones = (16'h1 << width) - 16'h1;
        push_word(ones, width);
        push_word(16'h0, width);
        push_word(16'h0, width);
        push_word(16'(tag) << (width - 8), width);
    endtask

    // ----------------------------------------------------------------------
    // Stream builder and line driver
    // ----------------------------------------------------------------------
    task automatic build_line(input line_row_t row);
        int          width;
        logic [15:0] mask;
        logic [15:0] value;
        lvds_byte_t  packed_byte;
        width = pixel_width(row.fmt);
        mask  = (16'h1 << width) - 16'h1;
        stream_bits.delete();
        line_bytes.delete();
        expected_pixels.delete();
        repeat (row.offset) stream_bits.push_back(1'b0);
        push_code(row.sav_ok ? TAG_SAV_VALID : TAG_SAV_INVALID, width);
        for (int i = 0; i < row.pixels; i++) begin
            rng_state = xorshift32(rng_state);
            value     = rng_state[15:0] & mask;
            push_word(value, width);
            expected_pixels.push_back(pixel_t'(value << (PIX_W - width)));
        end
        push_code(TAG_EAV_VALID, width);
        while (stream_bits.size() % 8 != 0) begin
            stream_bits.push_back(1'b0);
        end
        for (int i = 0; i < stream_bits.size(); i += 8) begin
            for (int j = 0; j < 8; j++) begin
                packed_byte[7-j] = stream_bits[i+j];
            end
            line_bytes.push_back(packed_byte);
        end
    endtask

    task automatic send_byte(input lvds_byte_t value);
        @(negedge camera_clk);
        lvds_data = value;
    endtask

    task automatic run_line(input line_row_t row);
        int half;
        build_line(row);
        half = line_bytes.size() / 2;
        @(negedge camera_clk);
        xhs       = 1'b1;
        lvds_data = '0;
        repeat (IDLE_BYTES) send_byte(8'h00);
        for (int i = 0; i < line_bytes.size(); i++) begin
            send_byte(line_bytes[i]);
            if (row.hs_early && i == half) begin
                xhs = 1'b0;
            end
        end
        repeat (PAD_BYTES) send_byte(8'h00);
        @(negedge camera_clk);
        xhs = 1'b0;
        repeat (SETTLE_CYCLES) @(negedge camera_clk);
    endtask

    task automatic check_line(input line_row_t row);
        line_addr_t exp_length;
        exp_length = row.exp_valid ? line_addr_t'(row.pixels) : '0;
        check_equal("o_line_valid", 32'(row.exp_valid), 32'(line_valid));
        check_equal("o_line_length", 32'(exp_length), 32'(line_length));
        if (row.sav_ok) begin
            check_equal("o_pixel_format", 32'(row.fmt), 32'(pixel_format));
        end
        if (row.exp_valid) begin
            rd_addr = '0;
            for (int k = 0; k < row.pixels; k++) begin
                @(negedge camera_clk);   // Read data lags the address by one cycle.
                check_equal("o_rd_data", 32'(expected_pixels[k]), 32'(rd_data));
                rd_addr = line_addr_t'(k + 1);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst         = 1'b1;
        xhs         = 1'b0;
        lvds_data   = '0;
        rd_addr     = '0;
        cycle_limit = cycle_budget();
        repeat (8) @(negedge camera_clk);
        rst = 1'b0;
        @(negedge camera_clk);
        check_equal("o_line_valid", 32'd0, 32'(line_valid));
        check_equal("o_line_length", 32'd0, 32'(line_length));
        check_equal("o_pixel_format", 32'(FMT_NONE), 32'(pixel_format));

        for (int r = 0; r < LINE_COUNT; r++) begin
            run_line(LINE_TABLE[r]);
            check_line(LINE_TABLE[r]);
        end

        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== vlog.f ====
+incdir+dv
src/cam_rx_pkg.sv
src/line_sync_detect.sv
src/pixel_unpack.sv
src/line_writer.sv
src/line_buffer_ram.sv
src/cam_line_receiver.sv
dv/tb_cam_line_receiver.sv

// ==== Bender.yml ====
package:
  name: cam_line_receiver

sources:
  - src/cam_rx_pkg.sv
  - src/line_sync_detect.sv
  - src/pixel_unpack.sv
  - src/line_writer.sv
  - src/line_buffer_ram.sv
  - src/cam_line_receiver.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_cam_line_receiver.sv
